/* design/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data path width
`define XLEN 32

`define REG_ADDR_W 5

// first fetch after reset
`define RESET_PC 32'h0000_0000

`define INSTR_BYTES 4

`endif

/* design/isa_pkg.sv */
`include "core_defs.svh"

package isa_pkg;

	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_op     = 7'b0110011
	} opcode_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one instruction word, six views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
		alu_or, alu_and, alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
	} alu_op_e;

	typedef enum logic [1:0] {
		sz_byte = 2'b00,
		sz_half = 2'b01,
		sz_word = 2'b10
	} mem_size_e;

	typedef struct packed {
		logic [`REG_ADDR_W-1:0] rd;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`XLEN-1:0]       imm;
		alu_op_e                alu_op;
		logic                   use_imm;
		logic                   reg_write;
		logic                   is_load;
		logic                   is_store;
		logic                   is_branch;
		logic                   is_jal;
		logic                   is_jalr;
		logic                   is_lui;
		logic                   is_auipc;
		logic                   load_unsigned;
		mem_size_e              mem_size;
	} dec_t;

endpackage

/* design/bus_pkg.sv */
`include "core_defs.svh"

package bus_pkg;

	typedef struct packed {
		logic [`XLEN-1:0]     addr; // always word aligned
		logic [`XLEN-1:0]     wdata;
		logic [`XLEN/8-1:0]   wstrb;
		logic                 write;
	} mem_req_t;

	typedef struct packed {
		logic [`XLEN-1:0] rdata;
	} mem_rsp_t;

endpackage

/* design/decoder.sv */
module decoder import isa_pkg::*; (
	input  logic   clk,
	input  logic   rstn,
	input  logic   instr_valid,
	input  instr_u instr,
	output dec_t   dec
);

	dec_t nxt;

	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt,
			input logic reg_form);
		alu_op_e op;
		case (f3)
			3'b000: op = (reg_form && alt) ? alu_sub : alu_add;
			3'b001: op = alu_sll;
			3'b010: op = alu_slt;
			3'b011: op = alu_sltu;
			3'b100: op = alu_xor;
			3'b101: op = alt ? alu_sra : alu_srl; // funct7 picks arithmetic
			3'b110: op = alu_or;
			default: op = alu_and;
		endcase
		return op;
	endfunction

	function automatic alu_op_e branch_op(input logic [2:0] f3);
		alu_op_e op;
		case (f3)
			3'b000: op = alu_eq;
			3'b001: op = alu_ne;
			3'b100: op = alu_lt;
			3'b101: op = alu_ge;
			3'b110: op = alu_ltu;
			default: op = alu_geu;
		endcase
		return op;
	endfunction

	always_comb begin
		nxt = '0;
		nxt.rd = instr.r.rd;
		nxt.rs1 = instr.r.rs1;
		nxt.rs2 = instr.r.rs2;
		nxt.alu_op = alu_add;
		nxt.mem_size = mem_size_e'(instr.i.funct3[1:0]);
		nxt.load_unsigned = instr.i.funct3[2];
		case (opcode_e'(instr.r.opcode))
			op_lui, op_auipc: begin
				nxt.imm = {instr.u.imm, 12'b0};
				nxt.reg_write = 1'b1;
				nxt.is_lui = (instr.r.opcode == op_lui);
				nxt.is_auipc = (instr.r.opcode == op_auipc);
			end
			op_jal: begin
				nxt.imm = {{12{instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
					instr.j.imm10_1, 1'b0};
				nxt.reg_write = 1'b1;
				nxt.is_jal = 1'b1;
			end
			op_jalr: begin
				nxt.imm = {{20{instr.i.imm[11]}}, instr.i.imm};
				nxt.reg_write = 1'b1;
				nxt.is_jalr = 1'b1;
			end
			op_branch: begin
				nxt.imm = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
					instr.b.imm4_1, 1'b0};
				nxt.alu_op = branch_op(instr.b.funct3);
				nxt.is_branch = 1'b1;
			end
			op_load: begin
				nxt.imm = {{20{instr.i.imm[11]}}, instr.i.imm};
				nxt.use_imm = 1'b1;
				nxt.reg_write = 1'b1;
				nxt.is_load = 1'b1;
			end
			op_store: begin
				nxt.imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
				nxt.use_imm = 1'b1;
				nxt.is_store = 1'b1;
			end
			op_imm: begin
				nxt.imm = {{20{instr.i.imm[11]}}, instr.i.imm};
				nxt.use_imm = 1'b1;
				nxt.reg_write = 1'b1;
				nxt.alu_op = arith_op(instr.i.funct3, instr.r.funct7[5], 1'b0);
			end
			op_op: begin
				nxt.reg_write = 1'b1;
				nxt.alu_op = arith_op(instr.r.funct3, instr.r.funct7[5], 1'b1);
			end
			default: ;
		endcase
		nxt.reg_write = nxt.reg_write && (nxt.rd != '0); // x0 target is a no-op
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			dec <= '0;
		end else if (instr_valid) begin
			dec <= nxt;
		end
	end

	a_known_opcode: assert property (@(posedge clk) disable iff (!rstn)
		instr_valid |-> instr.r.opcode inside {op_lui, op_auipc, op_jal, op_jalr,
			op_branch, op_load, op_store, op_imm, op_op});

endmodule

/* design/reg_file.sv */
`include "core_defs.svh"

module reg_file (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic [`REG_ADDR_W-1:0] rs1,
	input  logic [`REG_ADDR_W-1:0] rs2,
	output logic [`XLEN-1:0]       src1,
	output logic [`XLEN-1:0]       src2,
	input  logic                   wr_en,
	input  logic [`REG_ADDR_W-1:0] wr_idx,
	input  logic [`XLEN-1:0]       wr_data
);

	logic [`XLEN-1:0] regs [1:31]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		src1 <= (rs1 == '0) ? '0 : regs[rs1];
		src2 <= (rs2 == '0) ? '0 : regs[rs2];
	end

endmodule

/* design/alu.sv */
`include "core_defs.svh"

module alu import isa_pkg::*; (
	input  logic             clk,
	input  logic [`XLEN-1:0] a,
	input  logic [`XLEN-1:0] src2,
	input  logic [`XLEN-1:0] imm_b,
	input  logic             use_imm,
	input  alu_op_e          op,
	output logic [`XLEN-1:0] result
);

	logic [`XLEN-1:0] b;
	logic [4:0]       shamt;
	logic             lt_s;
	logic             lt_u;
	logic             eq;

	assign b = use_imm ? imm_b : src2;
	assign shamt = b[4:0];
	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;
	assign eq = (a == b);

	always_ff @(posedge clk) begin
		case (op)
			alu_add: result <= a + b;
			alu_sub: result <= a - b;
			alu_sll: result <= a << shamt;
			alu_srl: result <= a >> shamt;
			alu_sra: result <= $signed(a) >>> shamt;
			alu_xor: result <= a ^ b;
			alu_or:  result <= a | b;
			alu_and: result <= a & b;
			alu_slt, alu_lt:   result <= {{(`XLEN-1){1'b0}}, lt_s};
			alu_sltu, alu_ltu: result <= {{(`XLEN-1){1'b0}}, lt_u};
			alu_ge:  result <= {{(`XLEN-1){1'b0}}, !lt_s};
			alu_geu: result <= {{(`XLEN-1){1'b0}}, !lt_u};
			alu_eq:  result <= {{(`XLEN-1){1'b0}}, eq};
			default: result <= {{(`XLEN-1){1'b0}}, !eq}; // ne
		endcase
	end

endmodule

/* design/fetch_unit.sv */
`include "core_defs.svh"

module fetch_unit import isa_pkg::*, bus_pkg::*; (
	input  logic             clk,
	input  logic             rstn,
	input  logic             start,
	input  logic [`XLEN-1:0] pc,
	output logic             req,
	input  logic             ack,
	input  mem_rsp_t         rsp,
	output logic [`XLEN-1:0] addr,
	output instr_u           instr,
	output logic             done
);

	typedef enum logic [1:0] {fs_idle, fs_req, fs_drop} fstate_e;

	fstate_e state;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= fs_idle;
			req <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				fs_idle: if (start) begin
					req <= 1'b1;
					state <= fs_req;
				end
				fs_req: if (ack) begin
					req <= 1'b0; // rdata taken this cycle
					state <= fs_drop;
				end
				fs_drop: if (!ack) begin
					done <= 1'b1;
					state <= fs_idle;
				end
				default: state <= fs_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == fs_idle && start) begin
			addr <= pc;
		end
		if (state == fs_req && ack) begin
			instr <= rsp.rdata;
		end
	end

endmodule

/* design/lsu.sv */
`include "core_defs.svh"

module lsu import isa_pkg::*, bus_pkg::*; (
	input  logic             clk,
	input  logic             rstn,
	input  logic             start,
	input  dec_t             dec,
	input  logic [`XLEN-1:0] base,
	input  logic [`XLEN-1:0] store_data,
	output logic             req,
	input  logic             ack,
	input  mem_rsp_t         rsp,
	output mem_req_t         out,
	output logic [`XLEN-1:0] load_data,
	output logic             done
);

	typedef enum logic [1:0] {ls_idle, ls_req, ls_drop} lstate_e;

	lstate_e          state;
	logic [`XLEN-1:0] addr;
	logic [1:0]       ofs;
	logic [`XLEN-1:0] lane_wdata;
	logic [3:0]       lane_strb;
	logic [`XLEN-1:0] rd_shift;
	logic [`XLEN-1:0] rd_ext;

	assign addr = base + dec.imm;

	always_comb begin
		case (dec.mem_size)
			sz_byte: begin
				lane_wdata = {24'b0, store_data[7:0]} << {addr[1:0], 3'b000};
				lane_strb = 4'b0001 << addr[1:0];
			end
			sz_half: begin
				lane_wdata = {16'b0, store_data[15:0]} << {addr[1:0], 3'b000};
				lane_strb = 4'b0011 << addr[1:0];
			end
			default: begin
				lane_wdata = store_data;
				lane_strb = 4'b1111;
			end
		endcase
	end

	// addressed lane moved down to bit 0
	assign rd_shift = rsp.rdata >> {ofs, 3'b000};

	always_comb begin
		case (dec.mem_size)
			sz_byte: rd_ext = {{24{rd_shift[7] & !dec.load_unsigned}}, rd_shift[7:0]};
			sz_half: rd_ext = {{16{rd_shift[15] & !dec.load_unsigned}}, rd_shift[15:0]};
			default: rd_ext = rsp.rdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ls_idle;
			req <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ls_idle: if (start) begin
					req <= 1'b1;
					state <= ls_req;
				end
				ls_req: if (ack) begin
					req <= 1'b0;
					state <= ls_drop;
				end
				ls_drop: if (!ack) begin
					done <= 1'b1;
					state <= ls_idle;
				end
				default: state <= ls_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ls_idle && start) begin
			out.addr <= {addr[`XLEN-1:2], 2'b00};
			out.write <= dec.is_store;
			out.wdata <= dec.is_store ? lane_wdata : '0;
			out.wstrb <= dec.is_store ? lane_strb : 4'b0000;
			ofs <= addr[1:0];
		end
		if (state == ls_req && ack && !out.write) begin
			load_data <= rd_ext;
		end
	end

	a_aligned: assert property (@(posedge clk) disable iff (!rstn)
		start && (dec.is_load || dec.is_store) |->
			(dec.mem_size != sz_half || !addr[0]) &&
			(dec.mem_size != sz_word || addr[1:0] == 2'b00));

endmodule

/* design/mem_arbiter.sv */
`include "core_defs.svh"

module mem_arbiter import bus_pkg::*; (
	input  logic             clk,
	input  logic             rstn,
	input  logic             f_req,
	input  logic [`XLEN-1:0] f_addr,
	output logic             f_ack,
	input  logic             l_req,
	input  mem_req_t         l_out,
	output logic             l_ack,
	output logic             port_req,
	output mem_req_t         port_out,
	input  logic             port_ack
);

	typedef enum logic [1:0] {own_none, own_fetch, own_lsu} owner_e;

	owner_e   owner;
	owner_e   cur;
	mem_req_t f_out;

	always_comb begin
		cur = owner;
		if (owner == own_none) begin
			if (l_req) begin
				cur = own_lsu; // lsu wins a tie
			end else if (f_req) begin
				cur = own_fetch;
			end
		end
	end

	assign f_out = '{addr: f_addr, default: '0};

	assign port_req = (cur == own_lsu) ? l_req : ((cur == own_fetch) ? f_req : 1'b0);
	assign port_out = (cur == own_lsu) ? l_out : f_out;
	assign f_ack = (cur == own_fetch) && port_ack;
	assign l_ack = (cur == own_lsu) && port_ack;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			owner <= own_none;
		end else if (owner == own_none) begin
			owner <= cur;
		end else if (!port_req && !port_ack) begin
			owner <= own_none; // handshake complete
		end
	end

endmodule

/* design/exec_ctrl.sv */
`include "core_defs.svh"

module exec_ctrl import isa_pkg::*; (
	input  logic             clk,
	input  logic             rstn,
	input  dec_t             dec,
	input  logic [`XLEN-1:0] src1,
	input  logic [`XLEN-1:0] alu_result,
	input  logic [`XLEN-1:0] load_data,
	input  logic             fetch_done,
	input  logic             lsu_done,
	output logic             fetch_start,
	output logic             lsu_start,
	output logic [`XLEN-1:0] pc,
	output logic             wr_en,
	output logic [`XLEN-1:0] wr_data
);

	typedef enum logic [2:0] {st_fetch, st_fwait, st_read, st_exec, st_mem, st_wb} state_e;

	state_e           state;
	logic             taken;
	logic [`XLEN-1:0] jalr_sum;
	logic [`XLEN-1:0] next_pc;

	assign taken = dec.is_branch && (alu_result != '0);
	assign jalr_sum = src1 + dec.imm;

	always_comb begin
		next_pc = pc + `INSTR_BYTES;
		if (dec.is_jal || taken) begin
			next_pc = pc + dec.imm;
		end else if (dec.is_jalr) begin
			next_pc = {jalr_sum[`XLEN-1:1], 1'b0};
		end
	end

	always_comb begin
		if (dec.is_lui) begin
			wr_data = dec.imm;
		end else if (dec.is_auipc) begin
			wr_data = pc + dec.imm;
		end else if (dec.is_jal || dec.is_jalr) begin
			wr_data = pc + `INSTR_BYTES; // link address
		end else if (dec.is_load) begin
			wr_data = load_data;
		end else begin
			wr_data = alu_result;
		end
	end

	assign wr_en = (state == st_wb) && dec.reg_write;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= st_fetch;
			pc <= `RESET_PC;
			fetch_start <= 1'b0;
			lsu_start <= 1'b0;
		end else begin
			fetch_start <= 1'b0;
			lsu_start <= 1'b0;
			case (state)
				st_fetch: begin
					fetch_start <= 1'b1;
					state <= st_fwait;
				end
				st_fwait: if (fetch_done) begin
					state <= st_read; // decoder loads on this edge
				end
				st_read: state <= st_exec;
				st_exec: if (dec.is_load || dec.is_store) begin
					lsu_start <= 1'b1;
					state <= st_mem;
				end else begin
					state <= st_wb;
				end
				st_mem: if (lsu_done) begin
					state <= st_wb;
				end
				st_wb: begin
					pc <= next_pc;
					fetch_start <= 1'b1; // next fetch right away
					state <= st_fwait;
				end
				default: state <= st_fetch;
			endcase
		end
	end

endmodule

/* design/rv_core.sv */
`include "core_defs.svh"

module rv_core import isa_pkg::*, bus_pkg::*; (
	input  logic     clk,
	input  logic     rstn,
	output logic     port_req,
	output mem_req_t port_out,
	input  logic     port_ack,
	input  mem_rsp_t port_in
);

	instr_u           instr;
	dec_t             dec;
	logic             fetch_start;
	logic             fetch_done;
	logic             lsu_start;
	logic             lsu_done;
	logic [`XLEN-1:0] src1;
	logic [`XLEN-1:0] src2;
	logic [`XLEN-1:0] alu_result;
	logic [`XLEN-1:0] load_data;
	logic [`XLEN-1:0] pc;
	logic             wr_en;
	logic [`XLEN-1:0] wr_data;
	logic             f_req;
	logic [`XLEN-1:0] f_addr;
	logic             f_ack;
	logic             l_req;
	mem_req_t         l_out;
	logic             l_ack;

	decoder decoder_i (.clk(clk), .rstn(rstn), .instr_valid(fetch_done), .instr(instr),
		.dec(dec));

	reg_file reg_file_i (.clk(clk), .rstn(rstn), .rs1(dec.rs1), .rs2(dec.rs2), .src1(src1),
		.src2(src2), .wr_en(wr_en), .wr_idx(dec.rd), .wr_data(wr_data));

	alu alu_i (.clk(clk), .a(src1), .src2(src2), .imm_b(dec.imm), .use_imm(dec.use_imm),
		.op(dec.alu_op), .result(alu_result));

	fetch_unit fetch_unit_i (.clk(clk), .rstn(rstn), .start(fetch_start), .pc(pc),
		.req(f_req), .ack(f_ack), .rsp(port_in), .addr(f_addr), .instr(instr),
		.done(fetch_done));

	lsu lsu_i (.clk(clk), .rstn(rstn), .start(lsu_start), .dec(dec), .base(src1),
		.store_data(src2), .req(l_req), .ack(l_ack), .rsp(port_in), .out(l_out),
		.load_data(load_data), .done(lsu_done));

	mem_arbiter mem_arbiter_i (.clk(clk), .rstn(rstn), .f_req(f_req), .f_addr(f_addr),
		.f_ack(f_ack), .l_req(l_req), .l_out(l_out), .l_ack(l_ack), .port_req(port_req),
		.port_out(port_out), .port_ack(port_ack));

	exec_ctrl exec_ctrl_i (.clk(clk), .rstn(rstn), .dec(dec), .src1(src1),
		.alu_result(alu_result), .load_data(load_data), .fetch_done(fetch_done),
		.lsu_done(lsu_done), .fetch_start(fetch_start), .lsu_start(lsu_start), .pc(pc),
		.wr_en(wr_en), .wr_data(wr_data));

endmodule

/* verification/tb_core.sv */
`include "core_defs.svh"

module tb_core import isa_pkg::*, bus_pkg::*; ();

	localparam int mem_words = 256;
	localparam int data_base = 'h200;
	localparam logic [6:0] opc_load = 7'b0000011;
	localparam logic [6:0] opc_imm = 7'b0010011;
	localparam logic [6:0] opc_jalr = 7'b1100111;
	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_auipc = 7'b0010111;

	logic        clk;
	logic        rstn;
	logic        port_req;
	mem_req_t    port_out;
	logic        port_ack;
	mem_rsp_t    port_in;
	logic [31:0] mem [0:mem_words-1];
	logic [31:0] image [0:mem_words-1];
	mem_req_t    exp_q [$];
	int          prog_len;
	int          out_ofs;
	int          n_seen;
	int          cycles;
	int          limit;
	logic        prev_req;

	rv_core dut_i (.clk(clk), .rstn(rstn), .port_req(port_req), .port_out(port_out),
		.port_ack(port_ack), .port_in(port_in));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic emit(input logic [31:0] w);
		image[prog_len] = w;
		prog_len++;
	endtask

	task automatic emit_store(input logic [4:0] rs);
		emit(enc_s(out_ofs[11:0], rs, 5'd2, 3'b010)); // sw rs, ofs(x2)
		out_ofs += 4;
	endtask

	task automatic load_program();
		int f3_r [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
		int f7_r [10] = '{0, 32, 0, 0, 0, 0, 0, 32, 0, 0};
		int f3_i [9] = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
		int imm_i [9] = '{-7, -3, 5, 'h5a5, 'h0f0, 'h7ff, 3, 9, 'h40d};
		int f3_b [6] = '{0, 1, 4, 5, 6, 7};
		int br_t1 [6] = '{14, 13, 13, 14, 14, 13}; // pairs that take the branch
		int br_t2 [6] = '{14, 14, 14, 13, 13, 14};
		int br_n1 [6] = '{13, 14, 14, 13, 13, 14}; // pairs that fall through
		int br_n2 [6] = '{14, 14, 13, 14, 14, 13};
		for (int a = 0; a < mem_words; a++) begin
			image[a] = {a[15:0], ~a[15:0]};
		end
		for (int k = 0; k < 4; k++) begin
			image[data_base / 4 + k] = $urandom();
		end
		image[data_base / 4] |= 32'h8000_8000; // sign bits set in bytes 1 and 3
		image[data_base / 4 + 1] &= 32'h7fff_ffff; // positive word
		prog_len = 0;
		out_ofs = 0;
		emit(enc_i(12'h200, 5'd0, 3'd0, 5'd1, opc_imm)); // x1 data base
		emit(enc_i(12'h300, 5'd0, 3'd0, 5'd2, opc_imm)); // x2 result base
		emit(enc_i(12'd0, 5'd1, 3'd2, 5'd3, opc_load));
		emit(enc_i(12'd4, 5'd1, 3'd2, 5'd4, opc_load));
		emit(enc_i(12'd1, 5'd1, 3'd0, 5'd5, opc_load)); // lb
		emit(enc_i(12'd3, 5'd1, 3'd4, 5'd6, opc_load)); // lbu
		emit(enc_i(12'd2, 5'd1, 3'd1, 5'd7, opc_load)); // lh
		emit(enc_i(12'd2, 5'd1, 3'd5, 5'd8, opc_load)); // lhu
		for (int r = 3; r <= 8; r++) begin
			emit_store(r[4:0]);
		end
		for (int k = 0; k < 10; k++) begin
			emit(enc_r(f7_r[k][6:0], 5'd4, 5'd3, f3_r[k][2:0], 5'd9));
			emit_store(5'd9);
		end
		for (int k = 0; k < 9; k++) begin
			emit(enc_i(imm_i[k][11:0], 5'd3, f3_i[k][2:0], 5'd10, opc_imm));
			emit_store(5'd10);
		end
		emit({20'habcde, 5'd11, opc_lui});
		emit_store(5'd11);
		emit({20'h00001, 5'd12, opc_auipc});
		emit_store(5'd12);
		emit(enc_s(out_ofs[11:0] + 12'd1, 5'd3, 5'd2, 3'b000)); // sb into lane 1
		emit(enc_s(out_ofs[11:0] + 12'd6, 5'd4, 5'd2, 3'b001)); // sh into upper half
		out_ofs += 8;
		emit(enc_i(12'd5, 5'd0, 3'd0, 5'd0, opc_imm)); // write to x0
		emit_store(5'd0);
		emit(enc_i(12'hfff, 5'd0, 3'd0, 5'd13, opc_imm));
		emit(enc_i(12'd1, 5'd0, 3'd0, 5'd14, opc_imm));
		emit(enc_i(12'd0, 5'd0, 3'd0, 5'd12, opc_imm));
		for (int k = 0; k < 6; k++) begin
			emit(enc_b(13'd8, br_t2[k][4:0], br_t1[k][4:0], f3_b[k][2:0]));
			emit(enc_i(12'd1, 5'd12, 3'd0, 5'd12, opc_imm)); // skipped
			emit(enc_b(13'd8, br_n2[k][4:0], br_n1[k][4:0], f3_b[k][2:0]));
			emit(enc_i(12'd1, 5'd12, 3'd0, 5'd12, opc_imm));
		end
		emit_store(5'd12);
		emit(enc_j(21'd8, 5'd15));
		emit(enc_i(12'd1, 5'd12, 3'd0, 5'd12, opc_imm));
		emit_store(5'd15);
		emit({20'h00000, 5'd16, opc_auipc});
		emit(enc_i(12'd12, 5'd16, 3'd0, 5'd17, opc_jalr));
		emit(enc_i(12'd1, 5'd12, 3'd0, 5'd12, opc_imm));
		emit_store(5'd17);
		emit_store(5'd12);
		emit(enc_j(21'd0, 5'd0)); // park
	endtask

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// runs the image by the ISA rules and records every port request in order
	function automatic void build_expected();
		logic [31:0] rm [0:mem_words-1];
		logic [31:0] x [0:31];
		logic [31:0] pc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [31:0] ld;
		logic [31:0] nxt;
		logic [2:0]  f3;
		mem_req_t    r;
		rm = image;
		for (int i = 0; i < 32; i++) begin
			x[i] = '0;
		end
		pc = `RESET_PC;
		exp_q.delete();
		for (int steps = 0; steps < 1000; steps++) begin
			ins = rm[pc[9:2]];
			r = '{addr: pc, wdata: '0, wstrb: '0, write: 1'b0};
			exp_q.push_back(r);
			a = x[ins[19:15]];
			b = x[ins[24:20]];
			f3 = ins[14:12];
			imm = {{20{ins[31]}}, ins[31:20]};
			nxt = pc + 32'd4;
			case (ins[6:0])
				7'b0110111: x[ins[11:7]] = {ins[31:12], 12'b0};
				7'b0010111: x[ins[11:7]] = pc + {ins[31:12], 12'b0};
				7'b1101111: begin
					imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
					x[ins[11:7]] = pc + 32'd4;
					nxt = pc + imm;
				end
				7'b1100111: begin
					nxt = (a + imm) & ~32'd1;
					x[ins[11:7]] = pc + 32'd4;
				end
				7'b1100011: begin
					imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
					if (branch_taken(f3, a, b)) begin
						nxt = pc + imm;
					end
				end
				7'b0000011: begin
					addr = a + imm;
					r = '{addr: {addr[31:2], 2'b00}, wdata: '0, wstrb: '0, write: 1'b0};
					exp_q.push_back(r);
					ld = rm[addr[9:2]] >> {addr[1:0], 3'b000};
					case (f3)
						3'd0: x[ins[11:7]] = {{24{ld[7]}}, ld[7:0]};
						3'd1: x[ins[11:7]] = {{16{ld[15]}}, ld[15:0]};
						3'd4: x[ins[11:7]] = {24'b0, ld[7:0]};
						3'd5: x[ins[11:7]] = {16'b0, ld[15:0]};
						default: x[ins[11:7]] = ld;
					endcase
				end
				7'b0100011: begin
					addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
					r.addr = {addr[31:2], 2'b00};
					r.write = 1'b1;
					case (f3)
						3'd0: begin
							r.wdata = {24'b0, b[7:0]} << {addr[1:0], 3'b000};
							r.wstrb = 4'b0001 << addr[1:0];
						end
						3'd1: begin
							r.wdata = {16'b0, b[15:0]} << {addr[1:0], 3'b000};
							r.wstrb = 4'b0011 << addr[1:0];
						end
						default: begin
							r.wdata = b;
							r.wstrb = 4'b1111;
						end
					endcase
					exp_q.push_back(r);
					for (int i = 0; i < 4; i++) begin
						if (r.wstrb[i]) rm[addr[9:2]][8*i +: 8] = r.wdata[8*i +: 8];
					end
				end
				7'b0010011: x[ins[11:7]] = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm);
				default: x[ins[11:7]] = alu_ref(f3, ins[30], a, b); // register form
			endcase
			x[0] = '0;
			if (nxt == pc) break; // jal to self
			pc = nxt;
		end
	endfunction

	task automatic compare_req(input mem_req_t got);
		mem_req_t want;
		want = exp_q[n_seen];
		if (got !== want) begin
			$display("error at %0t: request %0d got addr %h wdata %h wstrb %b write %b, %s",
				$time, n_seen, got.addr, got.wdata, got.wstrb, got.write, "mismatch");
			$display("error at %0t: expected addr %h wdata %h wstrb %b write %b",
				$time, want.addr, want.wdata, want.wstrb, want.write);
			$display("test failed");
			$fatal(1, "request mismatch");
		end
		n_seen++;
	endtask

	initial begin
		void'($urandom(86119));
		rstn = 1'b0;
		load_program();
		mem = image;
		build_expected();
		limit = 40 * exp_q.size() * 10;
		repeat (5) @(posedge clk);
		#10;
		rstn = 1'b1;
	end

	// memory model with random delay at each handshake phase
	initial begin
		port_ack = 1'b0;
		port_in = '0;
		forever begin
			do begin
				@(posedge clk);
				#10;
			end while (!port_req);
			repeat ($urandom_range(0, 3)) begin
				@(posedge clk);
				#10;
			end
			if (port_out.write) begin
				for (int i = 0; i < 4; i++) begin
					if (port_out.wstrb[i]) begin
						mem[port_out.addr[9:2]][8*i +: 8] = port_out.wdata[8*i +: 8];
					end
				end
			end else begin
				port_in.rdata = mem[port_out.addr[9:2]];
			end
			port_ack = 1'b1;
			do begin
				@(posedge clk);
				#10;
			end while (port_req);
			repeat ($urandom_range(0, 3)) begin
				@(posedge clk);
				#10;
			end
			port_ack = 1'b0;
		end
	end

	initial begin
		prev_req = 1'b0;
		n_seen = 0;
		cycles = 0;
		#1;
		while (n_seen < exp_q.size()) begin
			@(posedge clk);
			#5; // mid cycle between edge and input drive
			cycles++;
			if (cycles > limit) begin
				$display("timeout: the core did not finish the expected requests in time");
				$display("test failed");
				$fatal(1, "timeout");
			end
			if (rstn && port_req && !prev_req) begin
				if (port_ack) begin
					$display("a new request rose while ack was still high at %0t", $time);
					$display("test failed");
					$fatal(1, "handshake violation");
				end
				compare_req(port_out);
			end
			prev_req = port_req;
		end
		$display("test passed");
		$finish;
	end

endmodule

/* src.f */
+incdir+design
design/isa_pkg.sv
design/bus_pkg.sv
design/decoder.sv
design/reg_file.sv
design/alu.sv
design/fetch_unit.sv
design/lsu.sv
design/mem_arbiter.sv
design/exec_ctrl.sv
design/rv_core.sv
verification/tb_core.sv

/* Makefile */
SRCS := $(shell grep -v '^+' src.f)

.PHONY: all run clean

all: obj_dir/Vtb_core

obj_dir/Vtb_core: src.f $(SRCS) design/core_defs.svh
	verilator --binary --timing --assert -f src.f --top-module tb_core -o Vtb_core

run: obj_dir/Vtb_core
	./obj_dir/Vtb_core

clean:
	rm -rf obj_dir
